//--- logic/decode_pkg.sv
`default_nettype none

package decode_pkg;

   typedef logic [31:0] instr_t;        // one raw instruction word
   typedef logic [31:0] word_t;         // data word / 32 bit immediate
   typedef logic [4:0]  reg_idx_t;      // x0..x31
   typedef logic [4:0]  opcode_t;       // instr[6:2], low bits checked apart
   typedef logic [2:0]  funct3_t;
   typedef logic [4:0]  alu_op_t;
   typedef logic [2:0]  exec_stage_t;   // where execute goes next
   typedef logic [5:0]  branch_mask_t;  // one bit per branch condition
   typedef logic        s1_sel_t;       // alu operand 1 source
   typedef logic [1:0]  s2_sel_t;       // alu operand 2 source
   typedef logic [1:0]  reg_in_sel_t;   // register file write source

   // major opcodes, instr[6:2]
   localparam opcode_t OP_LOAD    = 5'b00000;
   localparam opcode_t OP_MISCMEM = 5'b00011;  // fence
   localparam opcode_t OP_OPIMM   = 5'b00100;
   localparam opcode_t OP_AUIPC   = 5'b00101;
   localparam opcode_t OP_STORE   = 5'b01000;
   localparam opcode_t OP_OP      = 5'b01100;
   localparam opcode_t OP_LUI     = 5'b01101;
   localparam opcode_t OP_BRANCH  = 5'b11000;
   localparam opcode_t OP_JALR    = 5'b11001;
   localparam opcode_t OP_JAL     = 5'b11011;  // bit 1 set, jalr has it clear
   localparam opcode_t OP_SYSTEM  = 5'b11100;

   // funct3 under OP / OP-IMM, same codes for the immediate forms
   localparam funct3_t FUNC_ADD_SUB = 3'b000;
   localparam funct3_t FUNC_SLL     = 3'b001;
   localparam funct3_t FUNC_SLT     = 3'b010;
   localparam funct3_t FUNC_SLTU    = 3'b011;
   localparam funct3_t FUNC_XOR     = 3'b100;
   localparam funct3_t FUNC_SRL_SRA = 3'b101;
   localparam funct3_t FUNC_OR      = 3'b110;
   localparam funct3_t FUNC_AND     = 3'b111;

   // funct3 under BRANCH, 010 and 011 undefined
   localparam funct3_t FUNC_BEQ  = 3'b000;
   localparam funct3_t FUNC_BNE  = 3'b001;
   localparam funct3_t FUNC_BLT  = 3'b100;
   localparam funct3_t FUNC_BGE  = 3'b101;
   localparam funct3_t FUNC_BLTU = 3'b110;
   localparam funct3_t FUNC_BGEU = 3'b111;

   localparam funct3_t FUNC_LW = 3'b010;       // word load

   localparam logic [6:0] FUNC7_MUL_DIV = 7'b0000001;  // M extension
   localparam logic [6:0] FUNC7_ALT     = 7'b0100000;  // sub / sra

   // alu operations
   localparam alu_op_t ALUOP_ADD    = 5'd0;
   localparam alu_op_t ALUOP_SUB    = 5'd1;
   localparam alu_op_t ALUOP_SLL    = 5'd2;
   localparam alu_op_t ALUOP_SLT    = 5'd3;
   localparam alu_op_t ALUOP_SLTU   = 5'd4;
   localparam alu_op_t ALUOP_XOR    = 5'd5;
   localparam alu_op_t ALUOP_SRL    = 5'd6;
   localparam alu_op_t ALUOP_SRA    = 5'd7;
   localparam alu_op_t ALUOP_OR     = 5'd8;
   localparam alu_op_t ALUOP_AND    = 5'd9;
   localparam alu_op_t ALUOP_MUL    = 5'd10;
   localparam alu_op_t ALUOP_MULH   = 5'd11;
   localparam alu_op_t ALUOP_MULHSU = 5'd12;
   localparam alu_op_t ALUOP_MULHU  = 5'd13;
   localparam alu_op_t ALUOP_DIV    = 5'd14;
   localparam alu_op_t ALUOP_DIVU   = 5'd15;
   localparam alu_op_t ALUOP_REM    = 5'd16;
   localparam alu_op_t ALUOP_REMU   = 5'd17;

   // datapath mux selects
   localparam s1_sel_t     MUX_ALUDAT1_REGVAL1 = 1'b0;
   localparam s1_sel_t     MUX_ALUDAT1_PC      = 1'b1;
   localparam s2_sel_t     MUX_ALUDAT2_REGVAL2 = 2'd0;
   localparam s2_sel_t     MUX_ALUDAT2_IMM     = 2'd1;
   localparam reg_in_sel_t MUX_REGINPUT_ALU    = 2'd0;
   localparam reg_in_sel_t MUX_REGINPUT_IMM    = 2'd1;

   // execute stage targets
   localparam exec_stage_t EXEC_TO_FETCH  = 3'd0;
   localparam exec_stage_t EXEC_TO_LOAD   = 3'd1;
   localparam exec_stage_t EXEC_TO_STORE  = 3'd2;
   localparam exec_stage_t EXEC_TO_BRANCH = 3'd3;
   localparam exec_stage_t EXEC_TO_SYSTEM = 3'd4;
   localparam exec_stage_t EXEC_TO_TRAP   = 3'd5;

endpackage

`default_nettype wire

//--- logic/imm_gen.sv
`default_nettype none

module imm_gen #(
   parameter int XLEN = 32                        // immediate word width
) (
   input  wire decode_pkg::instr_t i_instr,
   output logic [XLEN-1:0]         o_imm
);

   decode_pkg::opcode_t opcode;
   decode_pkg::word_t   imm32;                    // raw 32 bit immediate
   logic                sext;                     // extend from bit 31

   assign opcode = i_instr[6:2];

   always_comb begin
      sext = 1'b1;                                // all but U sign-extend
      case (opcode)
         decode_pkg::OP_STORE: begin              // S format
            imm32 = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
         end
         decode_pkg::OP_BRANCH: begin             // B format, bit 0 always 0
            imm32 = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                     i_instr[30:25], i_instr[11:8], 1'b0};
         end
         decode_pkg::OP_LUI,
         decode_pkg::OP_AUIPC: begin              // U format, low 12 zero
            imm32 = {i_instr[31:12], 12'b0};
            sext  = 1'b0;                         // upper bits zero-filled
         end
         decode_pkg::OP_JAL: begin                // J format
            imm32 = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                     i_instr[20], i_instr[30:21], 1'b0};
         end
         default: begin                           // I format, meaningless for R-type
            imm32 = {{20{i_instr[31]}}, i_instr[31:20]};
         end
      endcase
   end

   // widen to XLEN, no-op at 32
   always_comb begin
      if (sext) begin
         o_imm = XLEN'($signed(imm32));           // replicate bit 31
      end else begin
         o_imm = XLEN'(imm32);                    // zero extend
      end
   end

endmodule

`default_nettype wire

//--- logic/control_decode.sv
`default_nettype none

module control_decode (
   input  wire decode_pkg::instr_t        i_instr,
   output decode_pkg::alu_op_t            o_alu_op,
   output decode_pkg::s1_sel_t            o_s1_sel,
   output decode_pkg::s2_sel_t            o_s2_sel,
   output decode_pkg::reg_in_sel_t        o_reg_in_sel,
   output logic                           o_wb_from_alu,
   output logic                           o_wb_from_imm,
   output logic                           o_next_pc_from_alu,
   output logic                           o_write_reg,
   output decode_pkg::funct3_t            o_funct3,
   output decode_pkg::branch_mask_t       o_branch_mask,
   output decode_pkg::exec_stage_t        o_next_stage
);

   decode_pkg::opcode_t opcode;
   decode_pkg::funct3_t funct3;
   logic [6:0]          funct7;
   logic                full_word;               // low bits 11, not compressed
   logic                muldiv;                  // M extension under OP
   logic                alt;                     // sub / sra under OP

   assign opcode    = i_instr[6:2];
   assign funct3    = i_instr[14:12];
   assign funct7    = i_instr[31:25];
   assign full_word = (i_instr[1:0] == 2'b11);
   assign muldiv    = (funct7 == decode_pkg::FUNC7_MUL_DIV);
   assign alt       = (funct7 == decode_pkg::FUNC7_ALT);

   // compressed words see a word-load funct3
   assign o_funct3 = full_word ? funct3 : decode_pkg::FUNC_LW;

   // one-hot branch condition, zero for undefined funct3
   always_comb begin
      o_branch_mask = '0;
      if (full_word && opcode == decode_pkg::OP_BRANCH) begin
         case (funct3)
            decode_pkg::FUNC_BEQ:  o_branch_mask[0] = 1'b1;
            decode_pkg::FUNC_BNE:  o_branch_mask[1] = 1'b1;
            decode_pkg::FUNC_BLT:  o_branch_mask[2] = 1'b1;
            decode_pkg::FUNC_BGE:  o_branch_mask[3] = 1'b1;
            decode_pkg::FUNC_BLTU: o_branch_mask[4] = 1'b1;
            decode_pkg::FUNC_BGEU: o_branch_mask[5] = 1'b1;
            default:               o_branch_mask = '0;
         endcase
      end
   end

   always_comb begin
      o_alu_op           = decode_pkg::ALUOP_ADD;
      o_s1_sel           = decode_pkg::MUX_ALUDAT1_REGVAL1;
      o_s2_sel           = decode_pkg::MUX_ALUDAT2_REGVAL2;
      o_reg_in_sel       = decode_pkg::MUX_REGINPUT_ALU;
      o_wb_from_alu      = 1'b0;
      o_wb_from_imm      = 1'b0;
      o_next_pc_from_alu = 1'b0;
      o_write_reg        = 1'b0;
      o_next_stage       = decode_pkg::EXEC_TO_TRAP;  // unknown or compressed
      if (full_word) begin
         case (opcode)
            decode_pkg::OP_OP: begin              // reg-reg, M ops included
               case (funct3)
                  decode_pkg::FUNC_ADD_SUB: begin
                     if (muldiv)   o_alu_op = decode_pkg::ALUOP_MUL;
                     else if (alt) o_alu_op = decode_pkg::ALUOP_SUB;
                     else          o_alu_op = decode_pkg::ALUOP_ADD;
                  end
                  decode_pkg::FUNC_SLL: begin
                     o_alu_op = muldiv ? decode_pkg::ALUOP_MULH : decode_pkg::ALUOP_SLL;
                  end
                  decode_pkg::FUNC_SLT: begin
                     o_alu_op = muldiv ? decode_pkg::ALUOP_MULHSU : decode_pkg::ALUOP_SLT;
                  end
                  decode_pkg::FUNC_SLTU: begin
                     o_alu_op = muldiv ? decode_pkg::ALUOP_MULHU : decode_pkg::ALUOP_SLTU;
                  end
                  decode_pkg::FUNC_XOR: begin
                     o_alu_op = muldiv ? decode_pkg::ALUOP_DIV : decode_pkg::ALUOP_XOR;
                  end
                  decode_pkg::FUNC_SRL_SRA: begin
                     if (muldiv)   o_alu_op = decode_pkg::ALUOP_DIVU;
                     else if (alt) o_alu_op = decode_pkg::ALUOP_SRA;
                     else          o_alu_op = decode_pkg::ALUOP_SRL;
                  end
                  decode_pkg::FUNC_OR: begin
                     o_alu_op = muldiv ? decode_pkg::ALUOP_REM : decode_pkg::ALUOP_OR;
                  end
                  default: begin                  // FUNC_AND
                     o_alu_op = muldiv ? decode_pkg::ALUOP_REMU : decode_pkg::ALUOP_AND;
                  end
               endcase
               o_wb_from_alu = 1'b1;              // writeback happens in fetch
               o_next_stage  = decode_pkg::EXEC_TO_FETCH;
            end
            decode_pkg::OP_OPIMM: begin
               case (funct3)
                  decode_pkg::FUNC_SLL:  o_alu_op = decode_pkg::ALUOP_SLL;
                  decode_pkg::FUNC_SLT:  o_alu_op = decode_pkg::ALUOP_SLT;
                  decode_pkg::FUNC_SLTU: o_alu_op = decode_pkg::ALUOP_SLTU;
                  decode_pkg::FUNC_XOR:  o_alu_op = decode_pkg::ALUOP_XOR;
                  decode_pkg::FUNC_SRL_SRA: begin // srai has funct7 bit 5
                     o_alu_op = funct7[5] ? decode_pkg::ALUOP_SRA : decode_pkg::ALUOP_SRL;
                  end
                  decode_pkg::FUNC_OR:   o_alu_op = decode_pkg::ALUOP_OR;
                  decode_pkg::FUNC_AND:  o_alu_op = decode_pkg::ALUOP_AND;
                  default:               o_alu_op = decode_pkg::ALUOP_ADD;  // addi
               endcase
               o_s2_sel      = decode_pkg::MUX_ALUDAT2_IMM;
               o_wb_from_alu = 1'b1;
               o_next_stage  = decode_pkg::EXEC_TO_FETCH;
            end
            decode_pkg::OP_LOAD: begin            // address = rs1 + imm
               o_s2_sel     = decode_pkg::MUX_ALUDAT2_IMM;
               o_next_stage = decode_pkg::EXEC_TO_LOAD;
            end
            decode_pkg::OP_STORE: begin           // address = rs1 + imm
               o_s2_sel     = decode_pkg::MUX_ALUDAT2_IMM;
               o_next_stage = decode_pkg::EXEC_TO_STORE;
            end
            decode_pkg::OP_BRANCH: begin          // compare rs1 / rs2, mask picks test
               o_next_stage = decode_pkg::EXEC_TO_BRANCH;
            end
            decode_pkg::OP_JAL,
            decode_pkg::OP_JALR: begin
               o_write_reg        = 1'b1;         // link written in decode
               o_reg_in_sel       = decode_pkg::MUX_REGINPUT_ALU;
               o_s1_sel           = (opcode == decode_pkg::OP_JAL) ?
                                    decode_pkg::MUX_ALUDAT1_PC : decode_pkg::MUX_ALUDAT1_REGVAL1;
               o_s2_sel           = decode_pkg::MUX_ALUDAT2_IMM;
               o_next_pc_from_alu = 1'b1;         // target from alu sum
               o_next_stage       = decode_pkg::EXEC_TO_FETCH;
            end
            decode_pkg::OP_AUIPC: begin           // pc + imm
               o_s1_sel      = decode_pkg::MUX_ALUDAT1_PC;
               o_s2_sel      = decode_pkg::MUX_ALUDAT2_IMM;
               o_wb_from_alu = 1'b1;
               o_next_stage  = decode_pkg::EXEC_TO_FETCH;
            end
            decode_pkg::OP_LUI: begin             // imm straight to rd
               o_wb_from_imm = 1'b1;
               o_reg_in_sel  = decode_pkg::MUX_REGINPUT_IMM;
               o_next_stage  = decode_pkg::EXEC_TO_FETCH;
            end
            decode_pkg::OP_MISCMEM: o_next_stage = decode_pkg::EXEC_TO_FETCH;   // fence as nop
            decode_pkg::OP_SYSTEM:  o_next_stage = decode_pkg::EXEC_TO_SYSTEM;
            default:                o_next_stage = decode_pkg::EXEC_TO_TRAP;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- logic/instr_decoder.sv
`default_nettype none

module instr_decoder #(
   parameter int XLEN = 32                             // immediate width, 64 also builds
) (
   input  wire                            i_clk,
   input  wire                            i_reset,
   input  wire                            i_en,       // load strobe from execute
   input  wire decode_pkg::instr_t        i_instr,
   output decode_pkg::reg_idx_t           o_rs1,
   output decode_pkg::reg_idx_t           o_rs2,
   output decode_pkg::reg_idx_t           o_rd,
   output logic [XLEN-1:0]                o_imm,
   output decode_pkg::alu_op_t            o_alu_op,
   output decode_pkg::s1_sel_t            o_s1_sel,
   output decode_pkg::s2_sel_t            o_s2_sel,
   output decode_pkg::reg_in_sel_t        o_reg_in_sel,
   output logic                           o_wb_from_alu,
   output logic                           o_wb_from_imm,
   output logic                           o_next_pc_from_alu,
   output logic                           o_write_reg,
   output decode_pkg::funct3_t            o_funct3,
   output decode_pkg::branch_mask_t       o_branch_mask,
   output decode_pkg::exec_stage_t        o_next_stage
);

   logic [XLEN-1:0]            imm;                  // comb decode results
   decode_pkg::alu_op_t        alu_op;
   decode_pkg::s1_sel_t        s1_sel;
   decode_pkg::s2_sel_t        s2_sel;
   decode_pkg::reg_in_sel_t    reg_in_sel;
   logic                       wb_from_alu;
   logic                       wb_from_imm;
   logic                       next_pc_from_alu;
   logic                       write_reg;
   decode_pkg::funct3_t        funct3;
   decode_pkg::branch_mask_t   branch_mask;
   decode_pkg::exec_stage_t    next_stage;

   // register file is read during decode, so indices bypass the register
   assign o_rs1 = i_instr[19:15];
   assign o_rs2 = i_instr[24:20];
   assign o_rd  = i_instr[11:7];

   imm_gen #(
      .XLEN (XLEN)
   ) imm_gen_i (
      .i_instr (i_instr),
      .o_imm   (imm)
   );

   control_decode control_decode_i (
      .i_instr            (i_instr),
      .o_alu_op           (alu_op),
      .o_s1_sel           (s1_sel),
      .o_s2_sel           (s2_sel),
      .o_reg_in_sel       (reg_in_sel),
      .o_wb_from_alu      (wb_from_alu),
      .o_wb_from_imm      (wb_from_imm),
      .o_next_pc_from_alu (next_pc_from_alu),
      .o_write_reg        (write_reg),
      .o_funct3           (funct3),
      .o_branch_mask      (branch_mask),
      .o_next_stage       (next_stage)
   );

   always_ff @(posedge i_clk) begin
      if (i_reset) begin                              // inactive decode
         o_imm              <= '0;
         o_alu_op           <= decode_pkg::ALUOP_ADD;
         o_s1_sel           <= decode_pkg::MUX_ALUDAT1_REGVAL1;
         o_s2_sel           <= decode_pkg::MUX_ALUDAT2_REGVAL2;
         o_reg_in_sel       <= decode_pkg::MUX_REGINPUT_ALU;
         o_wb_from_alu      <= 1'b0;
         o_wb_from_imm      <= 1'b0;
         o_next_pc_from_alu <= 1'b0;
         o_write_reg        <= 1'b0;
         o_funct3           <= '0;
         o_branch_mask      <= '0;
         o_next_stage       <= decode_pkg::EXEC_TO_FETCH;
      end else if (i_en) begin                        // capture, else hold
         o_imm              <= imm;
         o_alu_op           <= alu_op;
         o_s1_sel           <= s1_sel;
         o_s2_sel           <= s2_sel;
         o_reg_in_sel       <= reg_in_sel;
         o_wb_from_alu      <= wb_from_alu;
         o_wb_from_imm      <= wb_from_imm;
         o_next_pc_from_alu <= next_pc_from_alu;
         o_write_reg        <= write_reg;
         o_funct3           <= funct3;
         o_branch_mask      <= branch_mask;
         o_next_stage       <= next_stage;
      end
   end

endmodule

`default_nettype wire

//--- tests/decoder_vectors.svh
// instr, i_en, imm, alu_op, {s1, s2, reg_in}, {write_reg, next_pc, wb_imm, wb_alu},
// funct3, branch mask, next stage (0 fetch 1 load 2 store 3 branch 4 system 5 trap)

// I format, both signs
add_row(32'h00a00093, 1, 32'h0000000a, 0, 5'b0_01_00, 4'b0001, 0, 6'b000000, 0); // addi x1,x0,10
add_row(32'hfff08113, 1, 32'hffffffff, 0, 5'b0_01_00, 4'b0001, 0, 6'b000000, 0); // addi x2,x1,-1
add_row(32'hff012303, 1, 32'hfffffff0, 0, 5'b0_01_00, 4'b0000, 2, 6'b000000, 1); // lw x6,-16(x2)
add_row(32'h004280e7, 1, 32'h00000004, 0, 5'b0_01_00, 4'b1100, 0, 6'b000000, 0); // jalr x1,4(x5)

// S format
add_row(32'h00512423, 1, 32'h00000008, 0, 5'b0_01_00, 4'b0000, 2, 6'b000000, 2); // sw x5,8(x2)
add_row(32'hfe512e23, 1, 32'hfffffffc, 0, 5'b0_01_00, 4'b0000, 2, 6'b000000, 2); // sw x5,-4(x2)

// B format over all eight funct3 codes
add_row(32'h00208863, 1, 32'h00000010, 0, 5'b0_00_00, 4'b0000, 0, 6'b000001, 3); // beq +16
add_row(32'hfe209ce3, 1, 32'hfffffff8, 0, 5'b0_00_00, 4'b0000, 1, 6'b000010, 3); // bne -8
add_row(32'h0020a863, 1, 32'h00000010, 0, 5'b0_00_00, 4'b0000, 2, 6'b000000, 3); // undefined 010
add_row(32'h0020b863, 1, 32'h00000010, 0, 5'b0_00_00, 4'b0000, 3, 6'b000000, 3); // undefined 011
add_row(32'h0020c863, 1, 32'h00000010, 0, 5'b0_00_00, 4'b0000, 4, 6'b000100, 3); // blt
add_row(32'h0020d863, 1, 32'h00000010, 0, 5'b0_00_00, 4'b0000, 5, 6'b001000, 3); // bge
add_row(32'h0020e863, 1, 32'h00000010, 0, 5'b0_00_00, 4'b0000, 6, 6'b010000, 3); // bltu
add_row(32'h0020f863, 1, 32'h00000010, 0, 5'b0_00_00, 4'b0000, 7, 6'b100000, 3); // bgeu

// enable low, new word on the bus but nothing captured
add_row(32'h123451b7, 0, 32'h00000000, 0, 5'b0_00_00, 4'b0000, 0, 6'b000000, 0);

// U format, upper immediates
add_row(32'h123451b7, 1, 32'h12345000, 0, 5'b0_00_01, 4'b0010, 5, 6'b000000, 0); // lui x3
add_row(32'hfffff1b7, 1, 32'hfffff000, 0, 5'b0_00_01, 4'b0010, 7, 6'b000000, 0); // lui negative
add_row(32'h80000217, 1, 32'h80000000, 0, 5'b1_01_00, 4'b0001, 0, 6'b000000, 0); // auipc x4

// J format
add_row(32'h001000ef, 1, 32'h00000800, 0, 5'b1_01_00, 4'b1100, 0, 6'b000000, 0); // jal x1,+2048
add_row(32'hffdff06f, 1, 32'hfffffffc, 0, 5'b1_01_00, 4'b1100, 7, 6'b000000, 0); // jal x0,-4

// fence and ecall
add_row(32'h0ff0000f, 1, 32'h000000ff, 0, 5'b0_00_00, 4'b0000, 0, 6'b000000, 0);
add_row(32'h00000073, 1, 32'h00000000, 0, 5'b0_00_00, 4'b0000, 0, 6'b000000, 4);

// traps, imm still follows the opcode field
add_row(32'h1234500b, 1, 32'h00000123, 0, 5'b0_00_00, 4'b0000, 5, 6'b000000, 5); // custom-0
add_row(32'h00a00091, 1, 32'h0000000a, 0, 5'b0_00_00, 4'b0000, 2, 6'b000000, 5); // addi, bits 01
add_row(32'h00208861, 1, 32'h00000010, 0, 5'b0_00_00, 4'b0000, 2, 6'b000000, 5); // beq, bits 01
add_row(32'h00000002, 1, 32'h00000000, 0, 5'b0_00_00, 4'b0000, 2, 6'b000000, 5); // bits 10

// hold again right after a trap
add_row(32'hffdff06f, 0, 32'h00000000, 0, 5'b0_00_00, 4'b0000, 0, 6'b000000, 0);
add_row(32'h4020d1b3, 0, 32'h00000000, 0, 5'b0_00_00, 4'b0000, 0, 6'b000000, 0); // sra x3,x1,x2

//--- tests/instr_decoder_tb.sv
`default_nettype none

module instr_decoder_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int RAND_COUNT = 16;                   // random R-type rows
   localparam int SWEEP_ROWS = 48;                   // OP and OP-IMM, 3 funct7 x 8 funct3

   typedef struct packed {
      decode_pkg::instr_t       instr;
      logic                     en;
      decode_pkg::word_t        imm;
      decode_pkg::alu_op_t      alu_op;
      logic [4:0]               sels;                // {s1, s2, reg_in}
      logic [3:0]               flags;               // {write_reg, next_pc, wb_imm, wb_alu}
      decode_pkg::funct3_t      funct3;
      decode_pkg::branch_mask_t mask;
      decode_pkg::exec_stage_t  stage;
   } row_t;

   logic                     i_clk;
   logic                     i_reset;
   logic                     i_en;
   decode_pkg::instr_t       i_instr;
   decode_pkg::reg_idx_t     o_rs1;
   decode_pkg::reg_idx_t     o_rs2;
   decode_pkg::reg_idx_t     o_rd;
   logic [31:0]              o_imm;
   decode_pkg::alu_op_t      o_alu_op;
   decode_pkg::s1_sel_t      o_s1_sel;
   decode_pkg::s2_sel_t      o_s2_sel;
   decode_pkg::reg_in_sel_t  o_reg_in_sel;
   logic                     o_wb_from_alu;
   logic                     o_wb_from_imm;
   logic                     o_next_pc_from_alu;
   logic                     o_write_reg;
   decode_pkg::funct3_t      o_funct3;
   decode_pkg::branch_mask_t o_branch_mask;
   decode_pkg::exec_stage_t  o_next_stage;

   row_t   rows[$];                                  // table, sweep, then random rows
   row_t   row;
   row_t   expected;                                 // what the output register should hold
   int     errors;
   int     checks;
   int     cycles;
   int     cycle_limit;
   integer seed;

   instr_decoder #(
      .XLEN (32)
   ) instr_decoder_i (.*);

   always #20 i_clk = ~i_clk;                        // 40 ns period

   always @(posedge i_clk) begin
      cycles = cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: decoder test still running after %0d cycles", cycles);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   task automatic add_row(input decode_pkg::instr_t instr, input logic en,
                          input decode_pkg::word_t imm, input decode_pkg::alu_op_t alu_op,
                          input logic [4:0] sels, input logic [3:0] flags,
                          input decode_pkg::funct3_t funct3,
                          input decode_pkg::branch_mask_t mask,
                          input decode_pkg::exec_stage_t stage);
      row_t r;
      r = {instr, en, imm, alu_op, sels, flags, funct3, mask, stage};
      rows.push_back(r);
   endtask

   task automatic load_table();
      `include "decoder_vectors.svh"
   endtask

   // base op by funct3, M ops and alternate forms picked by funct7
   function automatic decode_pkg::alu_op_t rule_alu_op(input logic is_op,
                                                       input decode_pkg::funct3_t f3,
                                                       input logic [6:0] f7);
      decode_pkg::alu_op_t op;
      case (f3)
         3'd0:    op = decode_pkg::ALUOP_ADD;
         3'd1:    op = decode_pkg::ALUOP_SLL;
         3'd2:    op = decode_pkg::ALUOP_SLT;
         3'd3:    op = decode_pkg::ALUOP_SLTU;
         3'd4:    op = decode_pkg::ALUOP_XOR;
         3'd5:    op = decode_pkg::ALUOP_SRL;
         3'd6:    op = decode_pkg::ALUOP_OR;
         default: op = decode_pkg::ALUOP_AND;
      endcase
      if (is_op && f7 == decode_pkg::FUNC7_MUL_DIV)
         op = decode_pkg::ALUOP_MUL + f3;            // mul .. remu in funct3 order
      else if (is_op && f7 == decode_pkg::FUNC7_ALT && f3 == 3'd0)
         op = decode_pkg::ALUOP_SUB;
      else if (f3 == 3'd5 && (is_op ? f7 == decode_pkg::FUNC7_ALT : f7[5]))
         op = decode_pkg::ALUOP_SRA;                 // srai only looks at bit 5
      return op;
   endfunction

   task automatic add_rtype_rows();
      logic [31:0]         r;
      logic [6:0]          f7;
      decode_pkg::funct3_t f3;
      decode_pkg::instr_t  instr;
      logic                sweep;
      logic                is_op;
      int                  k;
      for (int n = 0; n < SWEEP_ROWS + RAND_COUNT; n++) begin
         r     = $random(seed);                      // register fields always random
         sweep = (n < SWEEP_ROWS);
         is_op = !sweep || n < SWEEP_ROWS / 2;       // random rows are all OP
         k     = sweep ? (n / 8) % 3 : r[31:30] % 3;
         f7    = (k == 0) ? 7'h00 :
                 (k == 1) ? decode_pkg::FUNC7_ALT : decode_pkg::FUNC7_MUL_DIV;
         f3    = sweep ? 3'(n) : r[20:18];
         instr = {f7, r[17:13], r[12:8], f3, r[4:0], (is_op ? 7'b0110011 : 7'b0010011)};
         add_row(instr, 1'b1, 32'($signed(instr[31:20])), rule_alu_op(is_op, f3, f7),
                 {2'b00, !is_op, 2'b00}, 4'b0001, f3, 6'b0, decode_pkg::EXEC_TO_FETCH);
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      checks = checks + 1;
      if (got !== want) begin
         errors = errors + 1;
         $display("ERR %0t: %s is %0h, expected %0h", $time, name, got, want);
      end
   endtask

   task automatic check_registered();
      check_value("o_imm", o_imm, expected.imm);
      check_value("o_alu_op", o_alu_op, expected.alu_op);
      check_value("selects", {o_s1_sel, o_s2_sel, o_reg_in_sel}, expected.sels);
      check_value("flags", {o_write_reg, o_next_pc_from_alu, o_wb_from_imm, o_wb_from_alu},
                  expected.flags);
      check_value("o_funct3", o_funct3, expected.funct3);
      check_value("o_branch_mask", o_branch_mask, expected.mask);
      check_value("o_next_stage", o_next_stage, expected.stage);
   endtask

   initial begin
      i_clk    = 1'b0;
      i_reset  = 1'b1;
      i_en     = 1'b0;
      i_instr  = '0;
      errors   = 0;
      checks   = 0;
      cycles   = 0;
      seed     = 16166;
      expected = '0;                                 // inactive decode, all fields zero
      expected.alu_op = decode_pkg::ALUOP_ADD;
      expected.stage  = decode_pkg::EXEC_TO_FETCH;
      load_table();
      add_rtype_rows();
      cycle_limit = rows.size() * 2 + 20;            // one cycle per row, double margin
      repeat (2) @(posedge i_clk);
      @(negedge i_clk);
      i_reset = 1'b0;
      check_registered();                            // nothing enabled yet
      foreach (rows[n]) begin
         row     = rows[n];
         i_instr = row.instr;
         i_en    = row.en;
         #1;
         check_value("o_rs1", o_rs1, row.instr[19:15]);  // combinational path
         check_value("o_rs2", o_rs2, row.instr[24:20]);
         check_value("o_rd", o_rd, row.instr[11:7]);
         if (row.en)
            expected = row;                          // held rows keep the old values
         @(negedge i_clk);
         check_registered();
      end
      i_en = 1'b0;
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- compile.f
+incdir+tests
logic/decode_pkg.sv
logic/imm_gen.sv
logic/control_decode.sv
logic/instr_decoder.sv
tests/instr_decoder_tb.sv
